// ==== design/csr_pkg.sv ====
package csr_pkg;

    // CSR numbers
    localparam logic [13:0] CSR_CRMD   = 14'h0000;
    localparam logic [13:0] CSR_PRMD   = 14'h0001;
    localparam logic [13:0] CSR_ESTAT  = 14'h0005;
    localparam logic [13:0] CSR_ERA    = 14'h0006;
    localparam logic [13:0] CSR_EENTRY = 14'h000c;
    localparam logic [13:0] CSR_SAVE0  = 14'h0030;
    localparam logic [13:0] CSR_SAVE1  = 14'h0031;
    localparam logic [13:0] CSR_SAVE2  = 14'h0032;
    localparam logic [13:0] CSR_SAVE3  = 14'h0033;

    // Field positions
    localparam int CRMD_PLV_LO   = 0;
    localparam int CRMD_IE_BIT   = 2;
    localparam int PRMD_PIE_BIT  = 2;
    localparam int ESTAT_IS10_HI = 1;
    localparam int EENTRY_VA_LO  = 6;

    // Exception codes for ESTAT
    localparam logic [5:0] ECODE_SYS = 6'h0b;
    localparam logic [5:0] ECODE_INE = 6'h0d;

    // Opcodes
    localparam logic [7:0]  OP_CSR     = 8'h04;
    localparam logic [16:0] OP_SYSCALL = 17'h00056;
    localparam logic [16:0] OP_ERTN    = 17'h00c90;
    localparam logic [14:0] ERTN_CODE  = 15'h3800;

    // One instruction word, seen as CSR format or code format
    typedef union packed {
        struct packed {
            logic [7:0]  opcode;
            logic [13:0] csr_num;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } csr_fmt;
        struct packed {
            logic [16:0] opcode;
            logic [14:0] code;
        } code_fmt;
    } csr_inst_t;

    typedef enum logic [2:0] {
        CSRRD,
        CSRWR,
        CSRXCHG,
        SYSCALL,
        ERTN,
        ILLEGAL
    } inst_kind_t;

endpackage

// ==== design/csr_decode.sv ====
`timescale 1ns/100ps

module csr_decode (
    input  logic                clk,
    input  logic                resetn,
    input  logic                inst_valid,
    input  csr_pkg::csr_inst_t  inst,
    input  logic [31:0]         inst_pc,
    input  logic [31:0]         rj_value,
    input  logic [31:0]         rd_value,
    input  logic                flush,
    output logic                d_valid,
    output csr_pkg::inst_kind_t d_kind,
    output logic [13:0]         d_csr_num,
    output logic [31:0]         d_pc,
    output logic [31:0]         d_wvalue,
    output logic [31:0]         d_wmask
);
    import csr_pkg::*;

    inst_kind_t  kind;
    logic [13:0] csr_num;
    logic [31:0] wmask;

    // Classify the word through both views
    always_comb begin
        kind = ILLEGAL;
        if (inst.csr_fmt.opcode == OP_CSR) begin
            if (inst.csr_fmt.rj == 5'd0) begin
                kind = CSRRD;
            end else if (inst.csr_fmt.rj == 5'd1) begin
                kind = CSRWR;
            end else begin
                kind = CSRXCHG;
            end
        end else if (inst.code_fmt.opcode == OP_SYSCALL) begin
            kind = SYSCALL;
        end else if (inst.code_fmt.opcode == OP_ERTN && inst.code_fmt.code == ERTN_CODE) begin
            kind = ERTN;
        end
    end

    // ertn reads ERA through the normal read port
    assign csr_num = (kind == ERTN) ? CSR_ERA : inst.csr_fmt.csr_num;

    always_comb begin
        case (kind)
            CSRWR:   wmask = 32'hffff_ffff;
            CSRXCHG: wmask = rj_value;
            default: wmask = 32'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= inst_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            d_kind    <= kind;
            d_csr_num <= csr_num;
            d_pc      <= inst_pc;
            d_wvalue  <= rd_value;
            d_wmask   <= wmask;
        end
    end

endmodule

// ==== design/csr_writeback.sv ====
`timescale 1ns/100ps

module csr_writeback (
    input  logic                clk,
    input  logic                resetn,
    input  logic                d_valid,
    input  csr_pkg::inst_kind_t d_kind,
    input  logic [13:0]         d_csr_num,
    input  logic [31:0]         d_pc,
    input  logic [31:0]         d_wvalue,
    input  logic [31:0]         d_wmask,
    input  logic [31:0]         csr_rvalue,
    input  logic [31:0]         ex_entry,
    output logic [13:0]         csr_num,
    output logic                csr_we,
    output logic [31:0]         csr_wmask,
    output logic [31:0]         csr_wvalue,
    output logic                wb_ex,
    output logic [5:0]          wb_ecode,
    output logic [8:0]          wb_esubcode,
    output logic [31:0]         wb_pc,
    output logic                ertn_flush,
    output logic                flush,
    output logic                result_valid,
    output logic [31:0]         result,
    output logic                redirect_valid,
    output logic [31:0]         redirect_pc
);
    import csr_pkg::*;

    logic is_access;

    assign is_access = d_valid && (d_kind == CSRRD || d_kind == CSRWR || d_kind == CSRXCHG);

    // Strobes into the CSR file
    assign csr_num     = d_csr_num;
    assign csr_we      = d_valid && (d_kind == CSRWR || d_kind == CSRXCHG);
    assign csr_wmask   = d_wmask;
    assign csr_wvalue  = d_wvalue;
    assign wb_ex       = d_valid && (d_kind == SYSCALL || d_kind == ILLEGAL);
    assign wb_ecode    = (d_kind == SYSCALL) ? ECODE_SYS : ECODE_INE;
    assign wb_esubcode = 9'h0;
    assign wb_pc       = d_pc;
    assign ertn_flush  = d_valid && d_kind == ERTN;

    // Cancels the younger instruction at the decode input
    assign flush = wb_ex || ertn_flush;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            result_valid   <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            result_valid   <= is_access;
            redirect_valid <= flush;
        end
    end

    // Old CSR value, or ERA for ertn
    always_ff @(posedge clk) begin
        if (is_access) begin
            result <= csr_rvalue;
        end
        if (flush) begin
            redirect_pc <= wb_ex ? ex_entry : csr_rvalue;
        end
    end

endmodule

// ==== design/csr.sv ====
`timescale 1ns/100ps

module csr (
    input  logic        clk,
    input  logic        resetn,
    input  logic [13:0] csr_num,
    input  logic        csr_we,
    input  logic [31:0] csr_wmask,
    input  logic [31:0] csr_wvalue,
    input  logic        ertn_flush,
    input  logic        wb_ex,
    input  logic [5:0]  wb_ecode,
    input  logic [8:0]  wb_esubcode,
    input  logic [31:0] wb_pc,
    output logic [31:0] csr_rvalue,
    output logic [31:0] ex_entry
);
    import csr_pkg::*;

    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    logic [1:0]  estat_is10;
    logic [5:0]  estat_ecode;
    logic [8:0]  estat_esubcode;
    logic [31:0] era_pc;
    logic [31:EENTRY_VA_LO] eentry_va;
    logic [31:0] save_data [4];

    logic [31:0] crmd_rvalue;
    logic [31:0] prmd_rvalue;
    logic [31:0] estat_rvalue;
    logic [31:0] eentry_rvalue;
    logic [31:0] merged;
    logic        wr_save;

    // Masked write merges against the current read value of the addressed CSR
    assign merged  = (csr_wmask & csr_wvalue) | (~csr_wmask & csr_rvalue);
    assign wr_save = csr_we && csr_num[13:2] == CSR_SAVE0[13:2];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we && csr_num == CSR_CRMD) begin
            crmd_plv <= merged[CRMD_PLV_LO +: 2];
            crmd_ie  <= merged[CRMD_IE_BIT];
        end
    end

    // PPLV sits at the same position as PLV
    always_ff @(posedge clk) begin
        if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (csr_we && csr_num == CSR_PRMD) begin
            prmd_pplv <= merged[CRMD_PLV_LO +: 2];
            prmd_pie  <= merged[PRMD_PIE_BIT];
        end
    end

    // Only the two software interrupt bits are stored
    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_is10 <= 2'b0;
        end else if (csr_we && csr_num == CSR_ESTAT) begin
            estat_is10 <= merged[ESTAT_IS10_HI:0];
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
            era_pc         <= wb_pc;
        end else if (csr_we && csr_num == CSR_ERA) begin
            era_pc <= merged;
        end
        if (csr_we && csr_num == CSR_EENTRY) begin
            eentry_va <= merged[31:EENTRY_VA_LO];
        end
        if (wr_save) begin
            save_data[csr_num[1:0]] <= merged;
        end
    end

    // DA reads 1, PG, DATF and DATM read 0
    assign crmd_rvalue   = {23'b0, 2'b0, 2'b0, 1'b0, 1'b1, crmd_ie, crmd_plv};
    assign prmd_rvalue   = {29'b0, prmd_pie, prmd_pplv};
    assign estat_rvalue  = {1'b0, estat_esubcode, estat_ecode, 3'b0, 11'b0, estat_is10};
    assign eentry_rvalue = {eentry_va, {EENTRY_VA_LO{1'b0}}};

    always_comb begin
        case (csr_num)
            CSR_CRMD:   csr_rvalue = crmd_rvalue;
            CSR_PRMD:   csr_rvalue = prmd_rvalue;
            CSR_ESTAT:  csr_rvalue = estat_rvalue;
            CSR_ERA:    csr_rvalue = era_pc;
            CSR_EENTRY: csr_rvalue = eentry_rvalue;
            CSR_SAVE0,
            CSR_SAVE1,
            CSR_SAVE2,
            CSR_SAVE3:  csr_rvalue = save_data[csr_num[1:0]];
            default:    csr_rvalue = 32'h0;
        endcase
    end

    assign ex_entry = eentry_rvalue;

endmodule

// ==== design/csr_unit.sv ====
`timescale 1ns/100ps

module csr_unit (
    input  logic               clk,
    input  logic               resetn,
    input  logic               inst_valid,
    input  csr_pkg::csr_inst_t inst,
    input  logic [31:0]        inst_pc,
    input  logic [31:0]        rj_value,
    input  logic [31:0]        rd_value,
    output logic               result_valid,
    output logic [31:0]        result,
    output logic               redirect_valid,
    output logic [31:0]        redirect_pc
);
    import csr_pkg::*;

    // Decode stage outputs
    logic        d_valid;
    inst_kind_t  d_kind;
    logic [13:0] d_csr_num;
    logic [31:0] d_pc;
    logic [31:0] d_wvalue;
    logic [31:0] d_wmask;
    logic        flush;

    // CSR file port
    logic [13:0] csr_num;
    logic        csr_we;
    logic [31:0] csr_wmask;
    logic [31:0] csr_wvalue;
    logic        wb_ex;
    logic [5:0]  wb_ecode;
    logic [8:0]  wb_esubcode;
    logic [31:0] wb_pc;
    logic        ertn_flush;
    logic [31:0] csr_rvalue;
    logic [31:0] ex_entry;

    csr_decode u_decode (
        .clk        (clk),
        .resetn     (resetn),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .rj_value   (rj_value),
        .rd_value   (rd_value),
        .flush      (flush),
        .d_valid    (d_valid),
        .d_kind     (d_kind),
        .d_csr_num  (d_csr_num),
        .d_pc       (d_pc),
        .d_wvalue   (d_wvalue),
        .d_wmask    (d_wmask)
    );

    csr_writeback u_writeback (
        .clk            (clk),
        .resetn         (resetn),
        .d_valid        (d_valid),
        .d_kind         (d_kind),
        .d_csr_num      (d_csr_num),
        .d_pc           (d_pc),
        .d_wvalue       (d_wvalue),
        .d_wmask        (d_wmask),
        .csr_rvalue     (csr_rvalue),
        .ex_entry       (ex_entry),
        .csr_num        (csr_num),
        .csr_we         (csr_we),
        .csr_wmask      (csr_wmask),
        .csr_wvalue     (csr_wvalue),
        .wb_ex          (wb_ex),
        .wb_ecode       (wb_ecode),
        .wb_esubcode    (wb_esubcode),
        .wb_pc          (wb_pc),
        .ertn_flush     (ertn_flush),
        .flush          (flush),
        .result_valid   (result_valid),
        .result         (result),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    csr u_csr (
        .clk         (clk),
        .resetn      (resetn),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .ertn_flush  (ertn_flush),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .csr_rvalue  (csr_rvalue),
        .ex_entry    (ex_entry)
    );

endmodule

// ==== verif/csr_unit_checker.sv ====
`timescale 1ns/100ps

module csr_unit_checker (
    input logic clk,
    input logic resetn,
    input logic result_valid,
    input logic redirect_valid
);

    // One retired instruction gives one kind of output
    a_one_output: assert property (
        @(posedge clk) disable iff (!resetn) !(result_valid && redirect_valid))
        else $error("result_valid and redirect_valid are high in the same cycle");

    a_quiet_in_reset: assert property (
        @(posedge clk) !resetn |-> ##1 (!result_valid && !redirect_valid))
        else $error("output valid while reset is applied");

    // Decode is empty after reset, so writeback stays quiet one more cycle
    a_quiet_after_reset: assert property (
        @(posedge clk) !resetn |-> ##2 (!result_valid && !redirect_valid))
        else $error("output valid in the cycle after reset");

    // A redirect flushes the younger instruction
    a_no_double_redirect: assert property (
        @(posedge clk) disable iff (!resetn) redirect_valid |=> !redirect_valid)
        else $error("redirect_valid high on two consecutive cycles");

endmodule

// ==== verif/csr_unit_tb.sv ====
`timescale 1ns/100ps

module csr_unit_tb;
    import csr_pkg::*;

    localparam int TIMEOUT_CYCLES = 20;

    // Expected output of a row
    localparam int EXP_RESULT   = 0;
    localparam int EXP_REDIRECT = 1;
    localparam int EXP_NONE     = 2;
    localparam int EXP_ANY      = 3;  // result of a register with no reset value

    typedef struct {
        string       name;
        csr_inst_t   inst;
        logic [31:0] pc;
        logic [31:0] rj;
        logic [31:0] rd;
        int          kind;
        logic [31:0] exp_value;
        bit          b2b;
    } row_t;

    logic        clk;
    logic        resetn;
    logic        inst_valid;
    csr_inst_t   inst;
    logic [31:0] inst_pc;
    logic [31:0] rj_value;
    logic [31:0] rd_value;
    logic        result_valid;
    logic [31:0] result;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    row_t rows[$];

    csr_unit dut (
        .clk            (clk),
        .resetn         (resetn),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .rj_value       (rj_value),
        .rd_value       (rd_value),
        .result_valid   (result_valid),
        .result         (result),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    bind csr_unit csr_unit_checker u_checker (
        .clk            (clk),
        .resetn         (resetn),
        .result_valid   (result_valid),
        .redirect_valid (redirect_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // rj field 0 is csrrd, 1 is csrwr, anything else csrxchg
    function automatic csr_inst_t csr_word(input logic [13:0] num, input logic [4:0] rj);
        csr_inst_t w;
        w.csr_fmt.opcode  = OP_CSR;
        w.csr_fmt.csr_num = num;
        w.csr_fmt.rj      = rj;
        w.csr_fmt.rd      = 5'd4;
        return w;
    endfunction

    function automatic csr_inst_t code_word(input logic [16:0] op, input logic [14:0] code);
        csr_inst_t w;
        w.code_fmt.opcode = op;
        w.code_fmt.code   = code;
        return w;
    endfunction

    task automatic add_row(input string name, input csr_inst_t word, input logic [31:0] pc,
                           input logic [31:0] rj, input logic [31:0] rd, input int kind,
                           input logic [31:0] exp_value, input bit b2b);
        row_t r;
        r.name      = name;
        r.inst      = word;
        r.pc        = pc;
        r.rj        = rj;
        r.rd        = rd;
        r.kind      = kind;
        r.exp_value = exp_value;
        r.b2b       = b2b;
        rows.push_back(r);
    endtask

    task automatic build_table;
        add_row("rd_crmd_reset", csr_word(CSR_CRMD, 5'd0), 32'h1c00_0000,
                0, 0, EXP_RESULT, 32'h8, 0);
        add_row("rd_unknown", csr_word(14'h0100, 5'd0), 32'h1c00_0004,
                0, 0, EXP_RESULT, 32'h0, 0);
        add_row("init_save0", csr_word(CSR_SAVE0, 5'd1), 32'h1c00_0008,
                0, 32'h1111_0000, EXP_ANY, 0, 0);
        add_row("init_save1", csr_word(CSR_SAVE1, 5'd1), 32'h1c00_000c,
                0, 32'h2222_0001, EXP_ANY, 0, 0);
        add_row("init_save2", csr_word(CSR_SAVE2, 5'd1), 32'h1c00_0010,
                0, 32'h3333_0002, EXP_ANY, 0, 0);
        add_row("init_save3", csr_word(CSR_SAVE3, 5'd1), 32'h1c00_0014,
                0, 32'h4444_0003, EXP_ANY, 0, 0);
        // Write then read, issued back to back
        add_row("wr_save0", csr_word(CSR_SAVE0, 5'd1), 32'h1c00_0018,
                0, 32'ha5a5_0000, EXP_RESULT, 32'h1111_0000, 0);
        add_row("rd_save0", csr_word(CSR_SAVE0, 5'd0), 32'h1c00_001c,
                0, 0, EXP_RESULT, 32'ha5a5_0000, 1);
        add_row("wr_save1", csr_word(CSR_SAVE1, 5'd1), 32'h1c00_0020,
                0, 32'hb6b6_0001, EXP_RESULT, 32'h2222_0001, 1);
        add_row("rd_save1", csr_word(CSR_SAVE1, 5'd0), 32'h1c00_0024,
                0, 0, EXP_RESULT, 32'hb6b6_0001, 1);
        add_row("wr_save2", csr_word(CSR_SAVE2, 5'd1), 32'h1c00_0028,
                0, 32'hc7c7_0002, EXP_RESULT, 32'h3333_0002, 1);
        add_row("rd_save2", csr_word(CSR_SAVE2, 5'd0), 32'h1c00_002c,
                0, 0, EXP_RESULT, 32'hc7c7_0002, 1);
        add_row("wr_save3", csr_word(CSR_SAVE3, 5'd1), 32'h1c00_0030,
                0, 32'hd8d8_0003, EXP_RESULT, 32'h4444_0003, 1);
        add_row("rd_save3", csr_word(CSR_SAVE3, 5'd0), 32'h1c00_0034,
                0, 0, EXP_RESULT, 32'hd8d8_0003, 1);
        // Masked exchange; low half of SAVE1, PLV and IE of CRMD with DA written as 0
        add_row("xchg_save1", csr_word(CSR_SAVE1, 5'd6), 32'h1c00_0038,
                32'h0000_ffff, 32'h1234_5678, EXP_RESULT, 32'hb6b6_0001, 0);
        add_row("rd_save1_xchg", csr_word(CSR_SAVE1, 5'd0), 32'h1c00_003c,
                0, 0, EXP_RESULT, 32'hb6b6_5678, 1);
        add_row("xchg_crmd", csr_word(CSR_CRMD, 5'd6), 32'h1c00_0040,
                32'h0000_00ff, 32'h0000_0005, EXP_RESULT, 32'h8, 0);
        add_row("rd_crmd_xchg", csr_word(CSR_CRMD, 5'd0), 32'h1c00_0044,
                0, 0, EXP_RESULT, 32'hd, 1);
        // syscall with entry low bits set
        add_row("wr_eentry", csr_word(CSR_EENTRY, 5'd1), 32'h1c00_0048,
                0, 32'h1c00_803f, EXP_ANY, 0, 0);
        add_row("rd_eentry", csr_word(CSR_EENTRY, 5'd0), 32'h1c00_004c,
                0, 0, EXP_RESULT, 32'h1c00_8000, 0);
        add_row("syscall", code_word(OP_SYSCALL, 15'h0), 32'h1c00_0100,
                0, 0, EXP_REDIRECT, 32'h1c00_8000, 0);
        add_row("rd_estat_sys", csr_word(CSR_ESTAT, 5'd0), 32'h1c00_8000,
                0, 0, EXP_RESULT, 32'h000b_0000, 0);
        add_row("rd_era_sys", csr_word(CSR_ERA, 5'd0), 32'h1c00_8004,
                0, 0, EXP_RESULT, 32'h1c00_0100, 0);
        add_row("rd_crmd_sys", csr_word(CSR_CRMD, 5'd0), 32'h1c00_8008,
                0, 0, EXP_RESULT, 32'h8, 0);
        add_row("rd_prmd_sys", csr_word(CSR_PRMD, 5'd0), 32'h1c00_800c,
                0, 0, EXP_RESULT, 32'h5, 0);
        add_row("ertn", code_word(OP_ERTN, ERTN_CODE), 32'h1c00_8010,
                0, 0, EXP_REDIRECT, 32'h1c00_0100, 0);
        add_row("rd_crmd_ertn", csr_word(CSR_CRMD, 5'd0), 32'h1c00_0104,
                0, 0, EXP_RESULT, 32'hd, 0);
        // Undefined opcode
        add_row("illegal", 32'hffff_ffff, 32'h1c00_0300,
                0, 0, EXP_REDIRECT, 32'h1c00_8000, 0);
        add_row("rd_estat_ine", csr_word(CSR_ESTAT, 5'd0), 32'h1c00_8000,
                0, 0, EXP_RESULT, 32'h000d_0000, 0);
        add_row("rd_era_ine", csr_word(CSR_ERA, 5'd0), 32'h1c00_8004,
                0, 0, EXP_RESULT, 32'h1c00_0300, 0);
        add_row("rd_crmd_ine", csr_word(CSR_CRMD, 5'd0), 32'h1c00_8008,
                0, 0, EXP_RESULT, 32'h8, 0);
        // Younger csrwr is flushed by the syscall
        add_row("syscall_flush", code_word(OP_SYSCALL, 15'h0), 32'h1c00_0400,
                0, 0, EXP_REDIRECT, 32'h1c00_8000, 0);
        add_row("wr_flushed", csr_word(CSR_SAVE2, 5'd1), 32'h1c00_0404,
                0, 32'hdead_0002, EXP_NONE, 0, 1);
        add_row("rd_save2_kept", csr_word(CSR_SAVE2, 5'd0), 32'h1c00_8000,
                0, 0, EXP_RESULT, 32'hc7c7_0002, 0);
        // Younger exception is flushed too, ERA keeps the older pc
        add_row("syscall_flush_ex", code_word(OP_SYSCALL, 15'h0), 32'h1c00_0500,
                0, 0, EXP_REDIRECT, 32'h1c00_8000, 0);
        add_row("illegal_flushed", 32'hffff_ffff, 32'h1c00_0504,
                0, 0, EXP_NONE, 0, 1);
        add_row("rd_era_kept", csr_word(CSR_ERA, 5'd0), 32'h1c00_8000,
                0, 0, EXP_RESULT, 32'h1c00_0500, 0);
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_result(input string name, input logic [31:0] exp_value,
                                input logic [31:0] actual);
        if (actual !== exp_value) begin
            report_failure($sformatf("MISMATCH %s: expected result %h, actual %h",
                                     name, exp_value, actual));
        end
    endtask

    task automatic check_redirect(input string name, input logic [31:0] exp_value,
                                  input logic [31:0] actual);
        if (actual !== exp_value) begin
            report_failure($sformatf("MISMATCH %s: expected redirect_pc %h, actual %h",
                                     name, exp_value, actual));
        end
    endtask

    // The flushed slot follows the redirect by one cycle
    task automatic check_silent(input string name);
        @(negedge clk);
        if (result_valid || redirect_valid) begin
            report_failure($sformatf("Test %s should have been flushed but produced an output",
                                     name));
        end
    endtask

    task automatic wait_output(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!result_valid && !redirect_valid) begin
            if (cycles == TIMEOUT_CYCLES) begin
                report_failure($sformatf("Test %s produced no output within %0d cycles",
                                         name, TIMEOUT_CYCLES));
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic collect_row(input row_t r);
        if (r.kind == EXP_NONE) begin
            check_silent(r.name);
        end else begin
            wait_output(r.name);
            if (r.kind == EXP_REDIRECT) begin
                if (!redirect_valid) begin
                    report_failure($sformatf("Test %s expected a redirect but got a result",
                                             r.name));
                end else begin
                    check_redirect(r.name, r.exp_value, redirect_pc);
                end
            end else if (!result_valid) begin
                report_failure($sformatf("Test %s expected a result but got a redirect", r.name));
            end else if (r.kind == EXP_RESULT) begin
                check_result(r.name, r.exp_value, result);
            end
        end
    endtask

    task automatic drive_row(input row_t r);
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = r.inst;
        inst_pc    = r.pc;
        rj_value   = r.rj;
        rd_value   = r.rd;
    endtask

    // Drive a run of back-to-back rows while their outputs are collected
    task automatic run_group(input int first, input int last);
        int i;
        int j;
        fork
            begin
                for (i = first; i <= last; i++) begin
                    drive_row(rows[i]);
                end
                @(negedge clk);
                inst_valid = 1'b0;
            end
            begin
                for (j = first; j <= last; j++) begin
                    collect_row(rows[j]);
                end
            end
        join
    endtask

    initial begin
        int first;
        int last;
        resetn     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        inst_pc    = 32'h0;
        rj_value   = 32'h0;
        rd_value   = 32'h0;
        build_table();
        repeat (10) @(negedge clk);
        resetn = 1'b1;

        first = 0;
        while (first < rows.size()) begin
            last = first;
            while (last + 1 < rows.size() && rows[last + 1].b2b) begin
                last++;
            end
            run_group(first, last);
            first = last + 1;
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== vlog.f ====
design/csr_pkg.sv
design/csr_decode.sv
design/csr_writeback.sv
design/csr.sv
design/csr_unit.sv
verif/csr_unit_checker.sv
verif/csr_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
